// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

   localparam int WORD_W = 32;
   localparam int TAG_W  = 26;
   localparam int IDX_W  = 3;
   localparam int SETS   = 8;

   typedef logic [WORD_W-1:0] wordT;
   typedef logic [TAG_W-1:0]  tagT;
   typedef logic [IDX_W-1:0]  idxT;

   // field view of a byte address
   typedef struct packed
   {
      tagT        tag;
      idxT        idx;
      logic       blkOff;     // word within block
      logic [1:0] byteOff;
   } addrFieldsT;

   typedef union packed
   {
      wordT       word;       // flat view for the bus
      addrFieldsT f;
   } cacheAddrT;

   // word 0 sits at block offset 0
   typedef wordT [1:0] blockT;

endpackage

// ==== rtl/dcacheWay.sv ====
`timescale 1ns/1ps

module dcacheWay
(
   input  logic             CLK,
   input  logic             nRST,
   input  dcache_pkg::idxT  idx,
   input  dcache_pkg::tagT  tag,
   input  logic             fillEn,
   input  logic             fillSel,
   input  dcache_pkg::wordT fillData,
   input  logic             install,
   input  logic             writeEn,
   input  dcache_pkg::wordT writeData,
   input  logic             clean,
   input  logic             invalidateAll,
   output logic             hit,
   output logic             valid,
   output logic             dirty,
   output dcache_pkg::tagT  lineTag,
   output dcache_pkg::blockT lineData
);
   import dcache_pkg::*;

   tagT   tags [SETS];
   blockT data [SETS];
   logic [SETS-1:0] validBits;
   logic [SETS-1:0] dirtyBits;

   // lookup is combinational from the index
   assign lineTag  = tags[idx];
   assign lineData = data[idx];
   assign valid    = validBits[idx];
   assign dirty    = dirtyBits[idx];
   assign hit      = validBits[idx] && (tags[idx] == tag);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         validBits <= '0;
         dirtyBits <= '0;
      end
      else
      begin
         if (invalidateAll)
            validBits <= '0;
         else if (install)
            validBits[idx] <= 1'b1;

         if (install || clean)
            dirtyBits[idx] <= 1'b0;   // fresh fill or written back
         else if (writeEn)
            dirtyBits[idx] <= 1'b1;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (fillEn)
         data[idx][fillSel] <= fillData;
      else if (writeEn)
         data[idx][fillSel] <= writeData;   // fillSel carries block offset here

      if (install)
         tags[idx] <= tag;
   end

endmodule

// ==== rtl/dcacheCtrl.sv ====
`timescale 1ns/1ps

module dcacheCtrl
(
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  dmemREN,
   input  logic                  dmemWEN,
   input  dcache_pkg::cacheAddrT dmemAddr,
   input  dcache_pkg::wordT      dmemStore,
   input  logic                  halt,
   input  logic                  hit0,
   input  logic                  hit1,
   input  logic                  valid0,
   input  logic                  valid1,
   input  logic                  dirty0,
   input  logic                  dirty1,
   input  dcache_pkg::tagT       lineTag0,
   input  dcache_pkg::tagT       lineTag1,
   input  dcache_pkg::blockT     lineData0,
   input  dcache_pkg::blockT     lineData1,
   input  dcache_pkg::wordT      dLoad,
   input  logic                  dWait,
   output dcache_pkg::idxT       idx,
   output dcache_pkg::tagT       tag,
   output logic                  fillEn0,
   output logic                  fillEn1,
   output logic                  fillSel,
   output dcache_pkg::wordT      fillData,
   output logic                  install0,
   output logic                  install1,
   output logic                  writeEn0,
   output logic                  writeEn1,
   output dcache_pkg::wordT      writeData,
   output logic                  clean0,
   output logic                  clean1,
   output logic                  invalidateAll,
   output logic                  dhit,
   output dcache_pkg::wordT      dmemLoad,
   output logic                  flushed,
   output logic                  dREN,
   output logic                  dWEN,
   output dcache_pkg::cacheAddrT dAddr,
   output dcache_pkg::wordT      dStore
);
   import dcache_pkg::*;

   typedef enum logic [3:0]
   {
      IDLE, WRHIT, WDONE, WB0, WB1, FILL0, FILL1, INSTALL, FLSET, FLNEXT, FLDONE
   } stateT;

   stateT state, next;

   logic [SETS-1:0] lru;      // way to replace next
   idxT   flushIdx;
   logic  flushWay;
   logic  flushing;
   logic  victim;
   logic  selWay;
   logic  selDirty;
   logic  anyHit;
   logic  lastSet;
   tagT   selTag;
   blockT selLine;
   logic  doneWord;

   assign idx      = flushing ? flushIdx : dmemAddr.f.idx;
   assign tag      = dmemAddr.f.tag;
   assign anyHit   = hit0 || hit1;
   assign victim   = lru[idx];
   assign selWay   = flushing ? flushWay : victim;
   assign selDirty = selWay ? (valid1 && dirty1) : (valid0 && dirty0);
   assign selTag   = selWay ? lineTag1 : lineTag0;
   assign selLine  = selWay ? lineData1 : lineData0;
   assign lastSet  = flushWay && (flushIdx == idxT'(SETS - 1));
   assign doneWord = !dWait;

   // way strobes
   assign fillSel   = (state == WRHIT) ? dmemAddr.f.blkOff : (state == FILL1);
   assign fillData  = dLoad;
   assign fillEn0   = (state == FILL0 || state == FILL1) && doneWord && !victim;
   assign fillEn1   = (state == FILL0 || state == FILL1) && doneWord && victim;
   assign install0  = (state == INSTALL) && !victim;
   assign install1  = (state == INSTALL) && victim;
   assign writeData = dmemStore;
   assign writeEn0  = (state == WRHIT) && hit0;
   assign writeEn1  = (state == WRHIT) && hit1;
   assign clean0    = (state == WB1) && doneWord && !selWay;
   assign clean1    = (state == WB1) && doneWord && selWay;

   assign invalidateAll = (state == FLNEXT) && lastSet;
   assign flushed       = (state == FLDONE);

   // read hits answer in idle, writes two cycles later
   assign dhit = !halt && (((state == IDLE) && dmemREN && !dmemWEN && anyHit)
                           || (state == WDONE));
   assign dmemLoad = hit1 ? lineData1[dmemAddr.f.blkOff] : lineData0[dmemAddr.f.blkOff];

   always_comb
   begin
      next = state;
      case (state)
         IDLE:
         begin
            if (halt)
               next = FLSET;
            else if (dmemREN || dmemWEN)
            begin
               if (!anyHit)
                  next = selDirty ? WB0 : FILL0;
               else if (dmemWEN)
                  next = WRHIT;
            end
         end
         WRHIT:   next = WDONE;
         WDONE:   next = IDLE;
         WB0:     if (doneWord) next = WB1;
         WB1:     if (doneWord) next = flushing ? FLNEXT : FILL0;
         FILL0:   if (doneWord) next = FILL1;
         FILL1:   if (doneWord) next = INSTALL;
         INSTALL: next = IDLE;           // request replays as a hit
         FLSET:   next = selDirty ? WB0 : FLNEXT;
         FLNEXT:  next = lastSet ? FLDONE : FLSET;
         default: next = state;
      endcase
   end

   always_comb
   begin
      dREN   = 1'b0;
      dWEN   = 1'b0;
      dAddr  = '0;
      dStore = selLine[state == WB1];
      case (state)
         WB0, WB1:
         begin
            dWEN           = 1'b1;
            dAddr.f.tag    = selTag;      // victim's own address
            dAddr.f.idx    = idx;
            dAddr.f.blkOff = (state == WB1);
         end
         FILL0, FILL1:
         begin
            dREN           = 1'b1;
            dAddr.f.tag    = dmemAddr.f.tag;
            dAddr.f.idx    = idx;
            dAddr.f.blkOff = (state == FILL1);
         end
         default: ;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= IDLE;
         lru      <= '0;
         flushIdx <= '0;
         flushWay <= 1'b0;
         flushing <= 1'b0;
      end
      else
      begin
         state <= next;
         if ((state == IDLE) && halt)
            flushing <= 1'b1;
         if (state == FLNEXT)
         begin
            flushWay <= !flushWay;
            if (flushWay)
               flushIdx <= flushIdx + 1'b1;
         end
         if (state == INSTALL)
            lru[idx] <= !victim;
         else if (dhit)
            lru[idx] <= hit0;             // point at the other way
      end
   end

endmodule

// ==== rtl/dcacheTop.sv ====
`timescale 1ns/1ps

module dcacheTop
(
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  dmemREN,
   input  logic                  dmemWEN,
   input  dcache_pkg::cacheAddrT dmemAddr,
   input  dcache_pkg::wordT      dmemStore,
   input  logic                  halt,
   input  dcache_pkg::wordT      dLoad,
   input  logic                  dWait,
   output logic                  dhit,
   output dcache_pkg::wordT      dmemLoad,
   output logic                  flushed,
   output logic                  dREN,
   output logic                  dWEN,
   output dcache_pkg::cacheAddrT dAddr,
   output dcache_pkg::wordT      dStore
);
   import dcache_pkg::*;

   idxT   idx;
   tagT   tag;
   wordT  fillData, writeData;
   logic  fillSel, invalidateAll;
   logic  fillEn0, fillEn1, install0, install1;
   logic  writeEn0, writeEn1, clean0, clean1;
   logic  hit0, hit1, valid0, valid1, dirty0, dirty1;
   tagT   lineTag0, lineTag1;
   blockT lineData0, lineData1;

   dcacheWay way0 (.CLK, .nRST, .idx, .tag, .fillEn(fillEn0), .fillSel, .fillData,
                   .install(install0), .writeEn(writeEn0), .writeData, .clean(clean0),
                   .invalidateAll, .hit(hit0), .valid(valid0), .dirty(dirty0),
                   .lineTag(lineTag0), .lineData(lineData0));

   dcacheWay way1 (.CLK, .nRST, .idx, .tag, .fillEn(fillEn1), .fillSel, .fillData,
                   .install(install1), .writeEn(writeEn1), .writeData, .clean(clean1),
                   .invalidateAll, .hit(hit1), .valid(valid1), .dirty(dirty1),
                   .lineTag(lineTag1), .lineData(lineData1));

   dcacheCtrl ctrl (.CLK, .nRST, .dmemREN, .dmemWEN, .dmemAddr, .dmemStore, .halt,
                    .hit0, .hit1, .valid0, .valid1, .dirty0, .dirty1,
                    .lineTag0, .lineTag1, .lineData0, .lineData1, .dLoad, .dWait,
                    .idx, .tag, .fillEn0, .fillEn1, .fillSel, .fillData,
                    .install0, .install1, .writeEn0, .writeEn1, .writeData,
                    .clean0, .clean1, .invalidateAll, .dhit, .dmemLoad, .flushed,
                    .dREN, .dWEN, .dAddr, .dStore);

endmodule

// ==== tb/dcacheMem.sv ====
`timescale 1ns/1ps

module dcacheMem
(
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  dREN,
   input  logic                  dWEN,
   input  dcache_pkg::cacheAddrT dAddr,
   input  dcache_pkg::wordT      dStore,
   output dcache_pkg::wordT      dLoad,
   output logic                  dWait
);
   import dcache_pkg::*;

   wordT       mem [wordT];   // only written words are stored
   logic [1:0] waitLeft;
   integer     seed = 32'h7f3691e4;

   function automatic wordT readWord(wordT a);
      if (mem.exists(a))
         return mem[a];
      return a ^ 32'h5a5a0000;   // pattern of untouched words
   endfunction

   assign dLoad = readWord(dAddr.word);
   assign dWait = (dREN || dWEN) && (waitLeft != 2'd0);

   always @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         waitLeft <= 2'($random(seed));
      else if (dREN || dWEN)
      begin
         if (waitLeft != 2'd0)
            waitLeft <= waitLeft - 2'd1;
         else
         begin
            if (dWEN)
               mem[dAddr.word] = dStore;
            waitLeft <= 2'($random(seed));   // wait for the next access
         end
      end
   end

endmodule

// ==== tb/dcache_chk.sv ====
`timescale 1ns/1ps

module dcacheChk
(
   input logic                  CLK,
   input logic                  nRST,
   input logic                  dREN,
   input logic                  dWEN,
   input dcache_pkg::cacheAddrT dAddr,
   input logic                  dhit,
   input logic                  halt,
   input logic                  flushed
);
   int assertFails = 0;

   busOneWay: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
   else
   begin
      assertFails++;
      $error("dREN and dWEN are high together");
   end

   wordAligned: assert property (@(posedge CLK) disable iff (!nRST)
      (dREN || dWEN) |-> (dAddr.f.byteOff == 2'b00))
   else
   begin
      assertFails++;
      $error("dAddr is not word aligned during a bus access");
   end

   flushedHolds: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
   else
   begin
      assertFails++;
      $error("flushed fell before reset");
   end

   noHitInHalt: assert property (@(posedge CLK) disable iff (!nRST) halt |-> !dhit)
   else
   begin
      assertFails++;
      $error("dhit is high while halt is requested");
   end

endmodule

bind dcacheTop dcacheChk i_chk (.CLK, .nRST, .dREN, .dWEN, .dAddr, .dhit, .halt, .flushed);

// ==== tb/dcacheTb.sv ====
`timescale 1ns/1ps

module dcacheTb;
   import dcache_pkg::*;

   typedef enum logic [1:0] {READ, WRITE, FLUSH} opT;

   typedef struct
   {
      opT        op;
      cacheAddrT addr;
      wordT      data;
      logic      expMiss;   // fill seen on the bus
      int        expWb;     // write-back words on the bus
   } rowT;

   logic      CLK = 1'b0;
   logic      nRST, dmemREN, dmemWEN, halt;
   cacheAddrT dmemAddr, dAddr;
   wordT      dmemStore, dmemLoad, dLoad, dStore;
   logic      dhit, flushed, dREN, dWEN, dWait;

   rowT  rows [$];
   wordT shadow [wordT];
   int   errors = 0;
   int   passCount = 0;
   int   failCount = 0;
   int   cycleCount = 0;

   dcacheTop i_dut (.CLK, .nRST, .dmemREN, .dmemWEN, .dmemAddr, .dmemStore, .halt,
                    .dLoad, .dWait, .dhit, .dmemLoad, .flushed, .dREN, .dWEN, .dAddr,
                    .dStore);

   dcacheMem i_mem (.CLK, .nRST, .dREN, .dWEN, .dAddr, .dStore, .dLoad, .dWait);

   always #2 CLK = ~CLK;

   function automatic wordT shadowAt(wordT a);
      if (shadow.exists(a))
         return shadow[a];
      return a ^ 32'h5a5a0000;
   endfunction

   task automatic addRow(opT op, tagT t, idxT i, logic off, wordT d, logic miss, int wb);
      rowT row;
      row.op             = op;
      row.addr.f.tag     = t;
      row.addr.f.idx     = i;
      row.addr.f.blkOff  = off;
      row.addr.f.byteOff = 2'b00;
      row.data           = d;
      row.expMiss        = miss;
      row.expWb          = wb;
      rows.push_back(row);
   endtask

   task automatic buildTable();
      addRow(READ,  26'h10, 3'd1, 1'b0, 32'h0, 1'b1, 0);   // cold miss
      addRow(READ,  26'h10, 3'd1, 1'b1, 32'h0, 1'b0, 0);
      addRow(WRITE, 26'h10, 3'd1, 1'b0, 32'h11110000, 1'b0, 0);
      addRow(READ,  26'h10, 3'd1, 1'b0, 32'h0, 1'b0, 0);
      addRow(READ,  26'h10, 3'd1, 1'b1, 32'h0, 1'b0, 0);
      addRow(READ,  26'h20, 3'd2, 1'b0, 32'h0, 1'b1, 0);   // tag A of the LRU set
      addRow(READ,  26'h21, 3'd2, 1'b0, 32'h0, 1'b1, 0);   // B
      addRow(READ,  26'h20, 3'd2, 1'b0, 32'h0, 1'b0, 0);
      addRow(READ,  26'h22, 3'd2, 1'b0, 32'h0, 1'b1, 0);   // C evicts B
      addRow(READ,  26'h20, 3'd2, 1'b0, 32'h0, 1'b0, 0);
      addRow(READ,  26'h21, 3'd2, 1'b0, 32'h0, 1'b1, 0);
      addRow(WRITE, 26'h30, 3'd3, 1'b0, 32'ha0a00030, 1'b1, 0);
      addRow(WRITE, 26'h31, 3'd3, 1'b1, 32'hb0b00031, 1'b1, 0);
      addRow(READ,  26'h32, 3'd3, 1'b0, 32'h0, 1'b1, 2);   // dirty A goes out
      addRow(READ,  26'h33, 3'd3, 1'b0, 32'h0, 1'b1, 2);   // dirty B goes out
      addRow(READ,  26'h30, 3'd3, 1'b0, 32'h0, 1'b1, 0);
      addRow(READ,  26'h31, 3'd3, 1'b1, 32'h0, 1'b1, 0);
      addRow(WRITE, 26'h40, 3'd5, 1'b1, 32'hc0c00040, 1'b1, 0);
      addRow(WRITE, 26'h10, 3'd1, 1'b1, 32'hd0d00010, 1'b0, 0);
      addRow(FLUSH, 26'h0,  3'd0, 1'b0, 32'h0, 1'b0, 4);   // sets 1 and 5 dirty
   endtask

   task automatic checkWord(string name, wordT got, wordT exp);
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkBit(string name, logic got, logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic checkCount(string name, int got, int exp);
      if (got != exp)
      begin
         errors++;
         $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic reportTest(string name, int startErr);
      if (errors == startErr)
         passCount++;
      else
         failCount++;
      $display("%s: %s", name, (errors == startErr) ? "ok" : "failed");
   endtask

   task automatic runRow(int r);
      rowT  row;
      logic done;
      logic sawRead;
      int   cycles;
      int   wbCount;
      int   startErr;
      row      = rows[r];
      startErr = errors;
      done     = 1'b0;
      sawRead  = 1'b0;
      cycles   = 0;
      wbCount  = 0;
      @(posedge CLK);
      dmemREN   <= (row.op == READ);
      dmemWEN   <= (row.op == WRITE);
      dmemAddr  <= row.addr;
      dmemStore <= row.data;
      halt      <= (row.op == FLUSH);
      while (!done)
      begin
         @(negedge CLK);
         cycles++;
         if (dREN)
            sawRead = 1'b1;
         if (dWEN && !dWait)
         begin
            wbCount++;
            checkWord("dStore", dStore, shadowAt(dAddr.word));
         end
         done = (row.op == FLUSH) ? flushed : dhit;
      end
      if (row.op == READ)
      begin
         checkWord("dmemLoad", dmemLoad, shadowAt(row.addr.word));
         if (!row.expMiss)
            checkCount("hit latency", cycles, 1);
      end
      if (row.op == WRITE)
      begin
         if (!row.expMiss)
            checkCount("hit latency", cycles, 3);   // dhit two cycles after idle
         shadow[row.addr.word] = row.data;
      end
      if (row.op != FLUSH)
         checkBit("dREN seen", sawRead, row.expMiss);
      checkCount("write-back words", wbCount, row.expWb);
      reportTest($sformatf("row %0d %s %h", r, row.op.name(), row.addr.word), startErr);
   endtask

   initial
   begin
      int limit;
      wait (nRST === 1'b1);
      limit = rows.size() * 40 + SETS * 4 * 5 + 100;
      while (cycleCount < limit)
      begin
         @(posedge CLK);
         cycleCount++;
      end
      $display("timeout: the cache gave no answer within %0d cycles", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      int startErr;
      nRST      = 1'b0;
      dmemREN   = 1'b0;
      dmemWEN   = 1'b0;
      halt      = 1'b0;
      dmemAddr  = '0;
      dmemStore = '0;
      buildTable();
      repeat (10) @(posedge CLK);
      nRST <= 1'b1;
      @(negedge CLK);
      startErr = errors;
      checkBit("dREN", dREN, 1'b0);
      checkBit("dWEN", dWEN, 1'b0);
      checkBit("dhit", dhit, 1'b0);
      checkBit("flushed", flushed, 1'b0);
      reportTest("reset", startErr);
      foreach (rows[r])
         runRow(r);
      repeat (5) @(negedge CLK);
      startErr = errors;
      checkBit("flushed", flushed, 1'b1);   // still high after flush
      foreach (shadow[a])
         checkWord($sformatf("mem[%h]", a), i_mem.readWord(a), shadow[a]);
      reportTest("memory after flush", startErr);
      $display("tests passed %0d, tests failed %0d, assertion failures %0d",
               passCount, failCount, i_dut.i_chk.assertFails);
      if (failCount == 0 && i_dut.i_chk.assertFails == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/dcache_pkg.sv
rtl/dcacheWay.sv
rtl/dcacheCtrl.sv
rtl/dcacheTop.sv
tb/dcacheMem.sv
tb/dcache_chk.sv
tb/dcacheTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb -f compile.f
./obj_dir/VdcacheTb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -qx "ALL TESTS PASSED" sim.log
